// ==== ulpb_pkg.sv ====
`default_nettype none

package ulpb_pkg;

	// controller state of one member node
	typedef enum logic [3:0]
	{
		BUS_IDLE            = 4'd0,
		BUS_WAIT_START      = 4'd1,
		BUS_ARBITRATE       = 4'd2,
		BUS_PRIO            = 4'd3,
		BUS_ACTIVE          = 4'd4,
		BUS_INTERRUPT       = 4'd5,
		BUS_INTERRUPT_CHECK = 4'd6,
		BUS_SWITCH_ROLE     = 4'd7
	} bus_state_t;

	// cycles of CLK_EXT spent waiting after the start condition
	localparam int START_CYCLES = 4;

	// length of the window in which the data line toggles with CLK_EXT
	localparam int INTERRUPT_CYCLES = 6;

	// how long we wait for the toggling to come back around the ring
	localparam int CHECK_TIMEOUT = 8;

	// clocked cycles of the role switch phase
	localparam int CONTROL_CYCLES = 2;

	localparam int MAX_SHORT =
		(START_CYCLES > INTERRUPT_CYCLES) ? START_CYCLES : INTERRUPT_CYCLES;
	localparam int MAX_LONG =
		(CHECK_TIMEOUT > CONTROL_CYCLES) ? CHECK_TIMEOUT : CONTROL_CYCLES;
	localparam int MAX_CYCLES =
		(MAX_SHORT > MAX_LONG) ? MAX_SHORT : MAX_LONG;

	// the shared counter is loaded with a count minus one, so this width is enough
	localparam int CNT_W =
		(MAX_CYCLES > 1) ? $clog2(MAX_CYCLES) : 1;

endpackage

`default_nettype wire

// ==== ulpb_line_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpb_line_sampler
(
	input  logic CLK_EXT,
	input  logic RESETn,
	input  logic CLKIN,
	input  logic DIN,
	input  logic capture_en,
	output logic clkin_low,
	output logic din_neg,
	output logic din_pos
);

	// the returned clock is looked at in the middle of the high phase of CLK_EXT,
	// a member pulling it low there is asking for an interrupt
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clkin_low <= 1'b0;
		end
		else
		begin
			clkin_low <= ~CLKIN;
		end
	end

	// data line as seen at the falling edge during the interrupt window
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			din_neg <= 1'b0;
		end
		else if (capture_en)
		begin
			din_neg <= DIN;
		end
	end

	// the same line at the rising edge, a steady level gives equal samples
	// while a line toggling with the clock gives different ones
	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			din_pos <= 1'b0;
		end
		else if (capture_en)
		begin
			din_pos <= DIN;
		end
	end

endmodule

`default_nettype wire

// ==== ulpb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpb_ctrl
(
	input  logic                 CLK_EXT,
	input  logic                 RESETn,
	input  logic                 DIN,
	input  logic                 clkin_low,
	input  logic                 din_neg,
	input  logic                 din_pos,
	output ulpb_pkg::bus_state_t bus_state,
	output logic                 capture_en
);

	import ulpb_pkg::*;

	bus_state_t       next_bus_state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] next_cnt;
	logic             cnt_zero;
	logic             start_seen;
	logic             irq_seen;
	logic             ring_toggled;

	// start condition is the data line pulled low while nothing runs
	assign start_seen = ~DIN;

	// a member holding the returned clock low requests the interrupt
	assign irq_seen = clkin_low;

	// toggling came back if the two edge samples disagree
	assign ring_toggled = din_neg ^ din_pos;

	assign cnt_zero = (cnt == '0);

	// samples of the data line are only taken inside the interrupt window
	assign capture_en = (bus_state == BUS_INTERRUPT);

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			bus_state <= BUS_IDLE;
			cnt       <= '0;
		end
		else
		begin
			bus_state <= next_bus_state;
			cnt       <= next_cnt;
		end
	end

	// one down-counter serves every timed phase, it is reloaded with
	// the phase length minus one on entry and the phase ends when it reads zero
	always_comb
	begin
		next_bus_state = bus_state;
		next_cnt       = cnt;

		case (bus_state)
			BUS_IDLE:
			begin
				if (start_seen)
				begin
					next_bus_state = BUS_WAIT_START;
					next_cnt       = CNT_W'(START_CYCLES - 1);
				end
			end

			BUS_WAIT_START:
			begin
				if (cnt_zero)
				begin
					next_bus_state = BUS_ARBITRATE;
				end
				else
				begin
					next_cnt = cnt - 1'b1;
				end
			end

			// arbitration and priority are single fixed cycles on this node
			BUS_ARBITRATE:
			begin
				next_bus_state = BUS_PRIO;
			end

			BUS_PRIO:
			begin
				next_bus_state = BUS_ACTIVE;
			end

			BUS_ACTIVE:
			begin
				if (irq_seen)
				begin
					next_bus_state = BUS_INTERRUPT;
					next_cnt       = CNT_W'(INTERRUPT_CYCLES - 1);
				end
			end

			BUS_INTERRUPT:
			begin
				if (cnt_zero)
				begin
					next_bus_state = BUS_INTERRUPT_CHECK;
					next_cnt       = CNT_W'(CHECK_TIMEOUT - 1);
				end
				else
				begin
					next_cnt = cnt - 1'b1;
				end
			end

			BUS_INTERRUPT_CHECK:
			begin
				if (ring_toggled)
				begin
					next_bus_state = BUS_SWITCH_ROLE;
					next_cnt       = CNT_W'(CONTROL_CYCLES - 1);
				end
				else if (cnt_zero)
				begin
					// nothing came back, the ring is given up
					next_bus_state = BUS_IDLE;
				end
				else
				begin
					next_cnt = cnt - 1'b1;
				end
			end

			BUS_SWITCH_ROLE:
			begin
				if (cnt_zero)
				begin
					next_bus_state = BUS_IDLE;
				end
				else
				begin
					next_cnt = cnt - 1'b1;
				end
			end

			default:
			begin
				// unused encodings fall back to idle
				next_bus_state = BUS_IDLE;
				next_cnt       = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== ulpb_line_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpb_line_driver
(
	input  logic                 CLK_EXT,
	input  logic                 RESETn,
	input  logic                 DIN,
	input  ulpb_pkg::bus_state_t bus_state,
	output logic                 CLKOUT,
	output logic                 DOUT
);

	import ulpb_pkg::*;

	logic clk_en;
	logic clk_en_q;

	// the ring clock runs in these states only
	always_comb
	begin
		case (bus_state)
			BUS_ARBITRATE, BUS_PRIO, BUS_ACTIVE, BUS_SWITCH_ROLE:
			begin
				clk_en = 1'b1;
			end
			default:
			begin
				clk_en = 1'b0;
			end
		endcase
	end

	// the enable only changes while CLK_EXT is low, so the gate cannot cut a pulse short
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clk_en_q <= 1'b0;
		end
		else
		begin
			clk_en_q <= clk_en;
		end
	end

	// a stopped ring clock rests high
	assign CLKOUT = clk_en_q ? CLK_EXT : 1'b1;

	always_comb
	begin
		case (bus_state)
			BUS_IDLE, BUS_WAIT_START, BUS_ARBITRATE:
			begin
				DOUT = 1'b1;
			end
			// the data line carries the clock around the ring during the interrupt
			BUS_INTERRUPT, BUS_INTERRUPT_CHECK:
			begin
				DOUT = CLK_EXT;
			end
			default:
			begin
				DOUT = DIN;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== ulpb_mediator.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpb_mediator
(
	input  logic CLK_EXT,
	input  logic RESETn,
	input  logic CLKIN,
	input  logic DIN,
	output logic CLKOUT,
	output logic DOUT
);

	import ulpb_pkg::*;

	logic       clkin_low;
	logic       din_neg;
	logic       din_pos;
	logic       capture_en;
	bus_state_t bus_state;

	// input side, samples of the returned clock and the data line
	ulpb_line_sampler u_sampler
	(
		.CLK_EXT    (CLK_EXT),
		.RESETn     (RESETn),
		.CLKIN      (CLKIN),
		.DIN        (DIN),
		.capture_en (capture_en),
		.clkin_low  (clkin_low),
		.din_neg    (din_neg),
		.din_pos    (din_pos)
	);

	ulpb_ctrl u_ctrl
	(
		.CLK_EXT    (CLK_EXT),
		.RESETn     (RESETn),
		.DIN        (DIN),
		.clkin_low  (clkin_low),
		.din_neg    (din_neg),
		.din_pos    (din_pos),
		.bus_state  (bus_state),
		.capture_en (capture_en)
	);

	// output side, gated ring clock and data line selection
	ulpb_line_driver u_driver
	(
		.CLK_EXT   (CLK_EXT),
		.RESETn    (RESETn),
		.DIN       (DIN),
		.bus_state (bus_state),
		.CLKOUT    (CLKOUT),
		.DOUT      (DOUT)
	);

endmodule

`default_nettype wire

// ==== ulpb_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpb_asserts
(
	input logic                 CLK_EXT,
	input logic                 RESETn,
	input logic                 CLKOUT,
	input logic                 DOUT,
	input ulpb_pkg::bus_state_t bus_state
);

	import ulpb_pkg::*;

	// number of failed assertions so far
	int unsigned fail_count = 0;

	logic lines_quiet;
	logic data_is_clock;

	// nothing goes out onto the ring before the start delay has run out
	assign lines_quiet = (bus_state == BUS_IDLE) || (bus_state == BUS_WAIT_START);

	// the interrupt window and the check that follows it
	assign data_is_clock = (bus_state == BUS_INTERRUPT) || (bus_state == BUS_INTERRUPT_CHECK);

	reset_lines_high: assert property (@(posedge CLK_EXT) !RESETn |-> (CLKOUT && DOUT))
	else
	begin
		$error("CLKOUT or DOUT not high during reset");
		fail_count++;
	end

	quiet_lines_rise: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		lines_quiet |-> (CLKOUT && DOUT))
	else
	begin
		$error("CLKOUT or DOUT not high at a rising edge before the start delay ended");
		fail_count++;
	end

	quiet_lines_fall: assert property (@(negedge CLK_EXT) disable iff (!RESETn)
		lines_quiet |-> (CLKOUT && DOUT))
	else
	begin
		$error("CLKOUT or DOUT not high at a falling edge before the start delay ended");
		fail_count++;
	end

	// the ring clock rests high while the data line carries CLK_EXT
	intr_data_rise: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		data_is_clock |-> (CLKOUT && (DOUT == CLK_EXT)))
	else
	begin
		$error("interrupt lines wrong at a rising edge");
		fail_count++;
	end

	intr_data_fall: assert property (@(negedge CLK_EXT) disable iff (!RESETn)
		data_is_clock |-> (CLKOUT && (DOUT == CLK_EXT)))
	else
	begin
		$error("interrupt lines wrong at a falling edge");
		fail_count++;
	end

endmodule

bind ulpb_mediator ulpb_asserts u_asserts
(
	.CLK_EXT   (CLK_EXT),
	.RESETn    (RESETn),
	.CLKOUT    (CLKOUT),
	.DOUT      (DOUT),
	.bus_state (bus_state)
);

`default_nettype wire

// ==== tb_ulpb_mediator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ulpb_mediator;

	import ulpb_pkg::*;

	logic   CLK_EXT = 1'b0;
	logic   RESETn;
	logic   clkin;
	logic   din_level;
	logic   loop_en;
	logic   din;
	wire    ring_dout;
	logic   clkout;
	logic   dout;
	integer seed;
	string  test_name;

	always
	begin
		#5 CLK_EXT = ~CLK_EXT;
	end

	// the rest of the ring is one short delay, enough to keep the loop from closing on itself
	assign #1 ring_dout = dout;
	assign din = loop_en ? ring_dout : din_level;

	ulpb_mediator DUT
	(
		.CLK_EXT (CLK_EXT),
		.RESETn  (RESETn),
		.CLKIN   (clkin),
		.DIN     (din),
		.CLKOUT  (clkout),
		.DOUT    (dout)
	);

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s, %s: expected %b, actual %b", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("ERROR %s, %s: expected %0d, actual %0d", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic next_cycle();
		@(negedge CLK_EXT);
	endtask

	// outputs are read in the low half of CLK_EXT, after everything has settled
	task automatic settle();
		#2;
	endtask

	task automatic wait_clkout(input logic level, input int limit, output int waited);
		waited = 0;
		while (waited < limit)
		begin
			next_cycle();
			settle();
			waited++;
			if (clkout === level)
			begin
				return;
			end
		end
		$display("timeout in %s: CLKOUT did not go %b within %0d cycles", test_name, level, limit);
		abort_run();
	endtask

	task automatic idle_gap();
		logic [31:0] rnd;
		int          gap;
		rnd = $random(seed);
		gap = 2 + int'(rnd % 6);
		for (int i = 0; i < gap; i++)
		begin
			next_cycle();
			settle();
			check_bit("CLKOUT in idle", 1'b1, clkout);
			check_bit("DOUT in idle", 1'b1, dout);
		end
	endtask

	// start condition, then the start delay, arbitration, priority and a few active cycles
	task automatic run_start(input string name);
		logic [31:0] rnd;
		logic        bit_val;
		test_name = name;
		next_cycle();
		din_level <= 1'b0;
		settle();
		for (int i = 1; i <= START_CYCLES + 1; i++)
		begin
			next_cycle();
			din_level <= 1'b1;
			settle();
			if (i <= START_CYCLES)
			begin
				check_bit("CLKOUT during start delay", 1'b1, clkout);
			end
			else
			begin
				check_bit("CLKOUT after start delay", 1'b0, clkout);
			end
			check_bit("DOUT up to arbitration", 1'b1, dout);
		end
		for (int i = 0; i < 4; i++)
		begin
			next_cycle();
			rnd = $random(seed);
			bit_val = rnd[0];
			din_level <= bit_val;
			settle();
			check_bit("CLKOUT running", 1'b0, clkout);
			check_bit("DOUT follows DIN", bit_val, dout);
		end
	endtask

	task automatic run_interrupt(input string name, input logic loop_back);
		int waited;
		test_name = name;
		next_cycle();
		clkin <= 1'b0;
		din_level <= 1'b1;
		settle();
		check_bit("CLKOUT before request", 1'b0, clkout);
		next_cycle();
		clkin <= 1'b1;
		settle();
		check_bit("CLKOUT while request is sampled", 1'b0, clkout);
		wait_clkout(1'b1, 3, waited);
		check_count("cycles until CLKOUT stops", 1, waited);
		check_bit("DOUT equals CLK_EXT", CLK_EXT, dout);
		for (int i = 1; i < INTERRUPT_CYCLES; i++)
		begin
			next_cycle();
			if (loop_back)
			begin
				loop_en <= 1'b1;
			end
			settle();
			check_bit("CLKOUT frozen", 1'b1, clkout);
			check_bit("DOUT equals CLK_EXT", CLK_EXT, dout);
		end
	endtask

	task automatic check_role_switch();
		int   waited;
		int   pulses;
		logic running;
		test_name = "role switch";
		wait_clkout(1'b0, CHECK_TIMEOUT, waited);
		pulses = 1;
		running = 1'b1;
		for (int i = 0; i < CONTROL_CYCLES + 4; i++)
		begin
			next_cycle();
			loop_en <= 1'b0;
			din_level <= 1'b1;
			settle();
			if (clkout === 1'b0)
			begin
				if (!running)
				begin
					$display("%s: CLKOUT started again after the role switch ended", test_name);
					abort_run();
				end
				pulses++;
			end
			else
			begin
				running = 1'b0;
				check_bit("DOUT after role switch", 1'b1, dout);
			end
		end
		check_count("role switch pulses", CONTROL_CYCLES, pulses);
	endtask

	task automatic check_timeout();
		test_name = "check timeout";
		for (int i = 0; i < CHECK_TIMEOUT; i++)
		begin
			next_cycle();
			settle();
			check_bit("CLKOUT stays stopped", 1'b1, clkout);
			check_bit("DOUT equals CLK_EXT", CLK_EXT, dout);
		end
		next_cycle();
		settle();
		check_bit("CLKOUT back in idle", 1'b1, clkout);
		check_bit("DOUT back in idle", 1'b1, dout);
	endtask

	initial
	begin
		seed = 32'ha4d9_a3c8;
		test_name = "reset";
		RESETn <= 1'b0;
		clkin <= 1'b1;
		din_level <= 1'b1;
		loop_en <= 1'b0;
		repeat (3) @(posedge CLK_EXT);
		@(negedge CLK_EXT);
		RESETn <= 1'b1;

		test_name = "idle";
		idle_gap();
		run_start("start");
		run_interrupt("interrupt with ring loop", 1'b1);
		check_role_switch();
		test_name = "idle after role switch";
		idle_gap();
		run_start("second start");
		run_interrupt("interrupt without ring loop", 1'b0);
		check_timeout();
		test_name = "idle after timeout";
		idle_gap();
		run_start("start after timeout");
		next_cycle();
		settle();

		if (DUT.u_asserts.fail_count != 0)
		begin
			$display("%0d concurrent assertion failures", DUT.u_asserts.fail_count);
			abort_run();
		end
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
ulpb_pkg.sv
ulpb_line_sampler.sv
ulpb_ctrl.sv
ulpb_line_driver.sv
ulpb_mediator.sv
ulpb_asserts.sv
tb_ulpb_mediator.sv

// ==== Makefile ====
TOP := tb_ulpb_mediator
SRCS := $(wildcard *.sv)

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed" sim.log

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log
